// File: files.f
+incdir+include
src/decode_pkg.sv
src/decode_ifs.sv
src/decode_dispatch.sv
src/control_decoder.sv
src/decode_collector.sv
src/decode_stage.sv
test/decode_stage_tb.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - files:
      - src/decode_pkg.sv
      - src/decode_ifs.sv
      - src/decode_dispatch.sv
      - src/control_decoder.sv
      - src/decode_collector.sv
      - src/decode_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/decode_stage_tb.sv

// File: test/decode_tests.txt
# name instr0 instr1 flush hazard issue illegal ill_lane ctrl0 ctrl1
# all fields hex, ctrl words are decode_pkg::ctrl_word_t per lane
add_sub        003100B3 40628233 0 0 3 0 0 000000010000 100000010000
sll_sra        003110B3 4062D233 0 0 3 0 0 500000010000 700000010000
slt_sltu       003120B3 0062B233 0 0 3 0 0 000004014000 000008014000
xor_and        003140B3 0062F233 0 0 3 0 0 400000010000 200000010000
mul_mulhu      023100B3 0262B233 0 0 3 0 0 020000010008 080000010008
div_remu       023140B3 0262F233 0 0 3 0 0 004000010004 010000010004
addi_srai      00510093 4032D213 0 0 3 0 0 000000018000 700000018000
slti_sltiu     FFF12093 0072B213 0 0 3 0 0 00001001C000 00002001C000
lw_lbu         00412083 0002C203 0 0 3 0 0 000100058000 000200058000
sw_sb          00312423 00628023 0 0 3 0 0 002000028000 000800028000
beq_bgeu       00208063 0041F063 0 0 3 0 0 000003000000 000002080000
jal_jalr       000000EF 000302E7 0 0 3 0 0 000000010800 000000010400
lui_auipc      123450B7 00000117 0 0 3 0 0 000000019000 00000001A000
csrrw_x0_csrrs 34029073 34002373 0 0 3 0 0 0000000000C0 000000010120
csrrwi_mret    3401D3F3 30200073 0 0 3 0 0 0000000182E0 000000000010
flush_branch   00208063 000000EF 1 0 0 0 0 000001000001 000000000001
flush_illegal  0000007F 003100B3 1 0 0 0 0 000000000001 000000000001
raw_rs1        003100B3 40608233 0 0 1 0 0 000000010000 100000000001
raw_rs2        00012283 00532023 0 0 1 0 0 000100058000 002000008001
ext_hazard     003100B3 003140B3 0 1 0 0 0 000000000001 400000000001
bubble_lane1   00510093 00000000 0 0 1 1 1 000000018000 000000000003
illegal_lane0  0000007F 003100B3 0 0 0 1 0 000000000002 000000000000
illegal_lane1  003100B3 0002B203 0 0 1 1 1 000000010000 000000008002
illegal_funct7 203100B3 40628233 0 0 0 1 0 000000000002 100000000000

// File: test/decode_stage_tb.sv
`include "decode_params.svh"

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    in_valid;
    logic [`DEC_LANES-1:0][`INSTR_W-1:0]     in_instr;
    logic                                    in_flush;
    logic                                    in_hazard;
    logic                                    out_valid;
    decode_pkg::ctrl_word_t [`DEC_LANES-1:0] out_ctrl;
    logic [`DEC_LANES-1:0]                   out_issue;
    logic                                    out_illegal;
    logic [`DEC_LANE_W-1:0]                  out_illegal_lane;

    // test vectors, one entry per bundle
    string                                   names [$];
    logic [`DEC_LANES-1:0][`INSTR_W-1:0]     instrs [$];
    logic                                    flushes [$];
    logic                                    hazards [$];
    logic [`DEC_LANES-1:0]                   exp_issue [$];
    logic                                    exp_ill [$];
    logic [`DEC_LANE_W-1:0]                  exp_lane [$];
    decode_pkg::ctrl_word_t [`DEC_LANES-1:0] exp_ctrl [$];

    int idx_q [$];    // bundles in flight
    int stamp_q [$];  // cycle each one went in
    int cycle = 0;
    int limit = 1000;
    int mon_idx;
    int mon_stamp;

    decode_stage i_dut (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_ctrl(input string name, input int lane,
                              input decode_pkg::ctrl_word_t exp,
                              input decode_pkg::ctrl_word_t act);
        if (act !== exp)
            fail_run($sformatf("ERROR %s lane %0d ctrl expected %h actual %h",
                               name, lane, exp, act));
    endtask

    task automatic check_issue(input string name, input logic [`DEC_LANES-1:0] exp,
                               input logic [`DEC_LANES-1:0] act);
        if (act !== exp)
            fail_run($sformatf("ERROR %s issue expected %b actual %b", name, exp, act));
    endtask

    task automatic check_illegal(input string name, input logic exp_i,
                                 input logic [`DEC_LANE_W-1:0] exp_l, input logic act_i,
                                 input logic [`DEC_LANE_W-1:0] act_l);
        if (act_i !== exp_i || act_l !== exp_l)
            fail_run($sformatf("ERROR %s illegal/lane expected %b/%0d actual %b/%0d",
                               name, exp_i, exp_l, act_i, act_l));
    endtask

    task automatic load_tests();
        int                                      fd;
        int                                      r;
        string                                   name;
        string                                   rest;
        logic [63:0]                             word;
        logic [`DEC_LANES-1:0][`INSTR_W-1:0]     ins;
        logic [`DEC_LANES-1:0]                   iss;
        logic [`DEC_LANE_W-1:0]                  ln;
        logic                                    fl;
        logic                                    hz;
        logic                                    il;
        decode_pkg::ctrl_word_t [`DEC_LANES-1:0] cw;
        fd = $fopen("test/decode_tests.txt", "r");
        if (fd == 0)
            fail_run("could not open test/decode_tests.txt");
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", name);
            if (r != 1)
                break;
            if (name.substr(0, 0) == "#") begin  // column header
                r = $fgets(rest, fd);
                continue;
            end
            for (int k = 0; k < `DEC_LANES; k++) begin
                r = $fscanf(fd, "%h", word);
                ins[k] = word[`INSTR_W-1:0];
            end
            r = $fscanf(fd, "%h %h %h %h %h", fl, hz, iss, il, ln);
            if (r != 5)
                fail_run({"malformed line in test file at ", name});
            for (int k = 0; k < `DEC_LANES; k++) begin
                r = $fscanf(fd, "%h", word);
                cw[k] = word[$bits(decode_pkg::ctrl_word_t)-1:0];
            end
            names.push_back(name);
            instrs.push_back(ins);
            flushes.push_back(fl);
            hazards.push_back(hz);
            exp_issue.push_back(iss);
            exp_ill.push_back(il);
            exp_lane.push_back(ln);
            exp_ctrl.push_back(cw);
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle > limit)
            fail_run("timeout, the decoded bundles never arrived at the outputs");
    end

    ////////////////////////////////////////////////////
    // output monitor, sampled on the falling edge
    ////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (idx_q.size() == 0) begin
                fail_run("out_valid went high with no bundle in flight");
            end else begin
                mon_idx   = idx_q.pop_front();
                mon_stamp = stamp_q.pop_front();
                if (cycle - mon_stamp != 2)
                    fail_run($sformatf("ERROR %s latency expected 2 actual %0d",
                                       names[mon_idx], cycle - mon_stamp));
                check_issue(names[mon_idx], exp_issue[mon_idx], out_issue);
                check_illegal(names[mon_idx], exp_ill[mon_idx], exp_lane[mon_idx],
                              out_illegal, out_illegal_lane);
                for (int k = 0; k < `DEC_LANES; k++)
                    check_ctrl(names[mon_idx], k, exp_ctrl[mon_idx][k], out_ctrl[k]);
            end
        end
    end

    initial begin
        int gap;
        int n;
        void'($urandom(32'h7d53_e04e));
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_flush  = 1'b0;
        in_hazard = 1'b0;
        load_tests();
        n = names.size();
        limit = n + (n / 4 + 1) * 3 + 5 + 2 + 20;  // bundles, gaps, reset, latency, margin

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int t = 0; t < n; t++) begin
            in_valid  = 1'b1;
            in_instr  = instrs[t];
            in_flush  = flushes[t];
            in_hazard = hazards[t];
            idx_q.push_back(t);
            stamp_q.push_back(cycle);
            @(negedge clk);
            if (t % 4 == 3) begin  // idle gap between groups
                in_valid  = 1'b0;
                in_instr  = '0;
                in_flush  = 1'b0;
                in_hazard = 1'b0;
                gap = $urandom_range(3, 1);
                repeat (gap) @(negedge clk);
            end
        end
        in_valid = 1'b0;
        in_instr = '0;

        while (idx_q.size() > 0)
            @(negedge clk);
        repeat (3) @(negedge clk);  // no stray outputs

        if (n > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("no test vectors were run");
        end
    end

endmodule

// File: src/decode_stage.sv
`include "decode_params.svh"

module decode_stage (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic [`DEC_LANES-1:0][`INSTR_W-1:0]     in_instr,
    input  logic                                    in_flush,
    input  logic                                    in_hazard,
    output logic                                    out_valid,
    output decode_pkg::ctrl_word_t [`DEC_LANES-1:0] out_ctrl,
    output logic [`DEC_LANES-1:0]                   out_issue,
    output logic                                    out_illegal,
    output logic [`DEC_LANE_W-1:0]                  out_illegal_lane
);

    lane_in_if   lane_in [`DEC_LANES] (.clk(clk));
    lane_ctrl_if lane_ctrl [`DEC_LANES] ();

    decode_dispatch i_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_flush  (in_flush),
        .in_hazard (in_hazard),
        .lanes     (lane_in)
    );

    // one decoder per lane, purely combinational
    for (genvar g = 0; g < `DEC_LANES; g++) begin : g_dec
        control_decoder i_dec (
            .lane     (lane_in[g]),
            .ctrl_out (lane_ctrl[g])
        );
    end

    decode_collector i_collector (
        .clk              (clk),
        .rst_n            (rst_n),
        .lanes            (lane_ctrl),
        .out_valid        (out_valid),
        .out_ctrl         (out_ctrl),
        .out_issue        (out_issue),
        .out_illegal      (out_illegal),
        .out_illegal_lane (out_illegal_lane)
    );

endmodule

// File: src/decode_collector.sv
`include "decode_params.svh"

module decode_collector (
    input  logic                                    clk,
    input  logic                                    rst_n,
    lane_ctrl_if.collector                          lanes [`DEC_LANES],
    output logic                                    out_valid,
    output decode_pkg::ctrl_word_t [`DEC_LANES-1:0] out_ctrl,
    output logic [`DEC_LANES-1:0]                   out_issue,
    output logic                                    out_illegal,
    output logic [`DEC_LANE_W-1:0]                  out_illegal_lane
);

    localparam int LW = `DEC_LANE_W;

    logic [`DEC_LANES-1:0]                   v;
    decode_pkg::ctrl_word_t [`DEC_LANES-1:0] c;
    decode_pkg::ctrl_word_t [`DEC_LANES-1:0] c_m;  // write enables masked
    logic [`DEC_LANES-1:0]                   issue;
    logic                                    any_v;
    logic                                    ill_any;
    logic [LW-1:0]                           ill_lane;

    for (genvar k = 0; k < `DEC_LANES; k++) begin : g_lane
        assign v[k] = lanes[k].valid;
        assign c[k] = lanes[k].ctrl;
    end

    ////////////////////////////////////////////////////
    // in-order issue and illegal report
    ////////////////////////////////////////////////////
    always_comb begin
        logic run;
        run      = 1'b1;
        any_v    = |v;
        ill_any  = 1'b0;
        ill_lane = '0;
        c_m      = c;
        for (int k = 0; k < `DEC_LANES; k++) begin
            run      = run & v[k] & ~c[k].stalled & ~c[k].illegal;
            issue[k] = run;
            if (!run) begin
                c_m[k].regwrite = 1'b0;
                c_m[k].memwrite = 1'b0;
                c_m[k].memread  = 1'b0;
                c_m[k].csrwrite = 1'b0;
            end
        end
        for (int k = `DEC_LANES - 1; k >= 0; k--) begin  // lowest lane wins
            if (v[k] && c[k].illegal) begin
                ill_any  = 1'b1;
                ill_lane = LW'(k);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid        <= 1'b0;
            out_issue        <= '0;
            out_illegal      <= 1'b0;
            out_illegal_lane <= '0;
        end else begin
            out_valid        <= any_v;
            out_issue        <= issue;
            out_illegal      <= ill_any;
            out_illegal_lane <= ill_lane;
        end
    end

    always_ff @(posedge clk) begin
        out_ctrl <= c_m;
    end

    a_issue_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        ((out_issue + 1'b1) & out_issue) == '0);

endmodule

// File: src/control_decoder.sv
module control_decoder (
    lane_in_if.decoder   lane,
    lane_ctrl_if.decoder ctrl_out
);

    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [11:0]            funct12;
    logic [4:0]             rs1;
    logic [4:0]             rd;
    logic                   stall;
    decode_pkg::ctrl_word_t c;

    assign funct3  = lane.instr.r.funct3;
    assign funct7  = lane.instr.r.funct7;
    assign funct12 = lane.instr.i.funct12;  // system ops need the I view
    assign rs1     = lane.instr.r.rs1;
    assign rd      = lane.instr.r.rd;
    assign stall   = lane.flush | lane.hazard | lane.ins_zero;

    always_comb begin
        c = '0;
        unique case (decode_pkg::opcode_e'(lane.instr.r.opcode))
            decode_pkg::op_load: begin
                c.memread  = 1'b1;
                c.regwrite = 1'b1;
                c.alusrc   = 1'b1;
                unique case (funct3)
                    3'b000:  c.loadcntrl = 5'b00001;  // lb
                    3'b001:  c.loadcntrl = 5'b00010;  // lh
                    3'b010:  c.loadcntrl = 5'b00100;  // lw
                    3'b100:  c.loadcntrl = 5'b01000;  // lbu
                    3'b101:  c.loadcntrl = 5'b10000;  // lhu
                    default: c.illegal   = 1'b1;
                endcase
            end
            decode_pkg::op_op: begin
                c.regwrite = 1'b1;
                unique case ({funct7, funct3})
                    {7'h00, 3'b000}: c.alusel = 3'b000;  // add
                    {7'h20, 3'b000}: c.alusel = 3'b001;  // sub
                    {7'h00, 3'b001}: c.alusel = 3'b101;  // sll
                    {7'h00, 3'b010}: {c.compare, c.cmpcntrl} = 5'b1_0001;  // slt
                    {7'h00, 3'b011}: {c.compare, c.cmpcntrl} = 5'b1_0010;  // sltu
                    {7'h00, 3'b100}: c.alusel = 3'b100;  // xor
                    {7'h00, 3'b101}: c.alusel = 3'b110;  // srl
                    {7'h20, 3'b101}: c.alusel = 3'b111;  // sra
                    {7'h00, 3'b110}: c.alusel = 3'b011;  // or
                    {7'h00, 3'b111}: c.alusel = 3'b010;  // and
                    default: begin
                        // M extension, funct3 picks the unit op
                        if (funct7 == 7'h01 && !funct3[2]) begin
                            c.mulsel   = {1'b0, funct3[1:0]} + 3'd1;
                            c.mul_inst = 1'b1;
                        end else if (funct7 == 7'h01) begin
                            c.divsel   = {1'b0, funct3[1:0]} + 3'd1;
                            c.div_inst = 1'b1;
                        end else begin
                            c.illegal = 1'b1;
                        end
                    end
                endcase
            end
            decode_pkg::op_imm: begin
                c.regwrite = 1'b1;
                c.alusrc   = 1'b1;
                unique case (funct3)
                    3'b000: c.alusel = 3'b000;  // addi
                    3'b001: begin               // slli
                        if (funct7 == 7'h00) c.alusel = 3'b101;
                        else c.illegal = 1'b1;
                    end
                    3'b010: {c.compare, c.cmpcntrl} = 5'b1_0100;  // slti
                    3'b011: {c.compare, c.cmpcntrl} = 5'b1_1000;  // sltiu
                    3'b100: c.alusel = 3'b100;  // xori
                    3'b101: begin
                        if (funct7 == 7'h00) c.alusel = 3'b110;       // srli
                        else if (funct7 == 7'h20) c.alusel = 3'b111;  // srai
                        else c.illegal = 1'b1;
                    end
                    3'b110: c.alusel = 3'b011;  // ori
                    default: c.alusel = 3'b010;  // andi
                endcase
            end
            decode_pkg::op_store: begin
                c.memwrite = 1'b1;
                c.alusrc   = 1'b1;
                unique case (funct3)
                    3'b000:  c.storecntrl = 3'b001;  // sb
                    3'b001:  c.storecntrl = 3'b010;  // sh
                    3'b010:  c.storecntrl = 3'b100;  // sw
                    default: c.illegal    = 1'b1;
                endcase
            end
            decode_pkg::op_branch: begin
                c.branch = 1'b1;
                unique case (funct3)
                    3'b000:  c.beq     = 1'b1;
                    3'b001:  c.bne     = 1'b1;
                    3'b100:  c.blt     = 1'b1;
                    3'b101:  c.bge     = 1'b1;
                    3'b110:  c.bltu    = 1'b1;
                    3'b111:  c.bgeu    = 1'b1;
                    default: c.illegal = 1'b1;
                endcase
            end
            decode_pkg::op_jal: {c.jal, c.regwrite} = 2'b11;
            decode_pkg::op_jalr: {c.jalr, c.regwrite} = 2'b11;
            decode_pkg::op_lui: {c.lui, c.alusrc, c.regwrite} = 3'b111;
            decode_pkg::op_auipc: {c.auipc, c.alusrc, c.regwrite} = 3'b111;
            decode_pkg::op_system: begin
                c.csrsel = funct3;
                c.alusrc = funct3[2];  // immediate CSR forms
                unique case (funct3[1:0])
                    2'b00: c.trap_ret = (funct3 == 3'b000) && (funct12 == 12'h302);  // mret
                    2'b01: begin  // csrrw, csrrwi
                        c.regwrite = (rd != 5'd0);
                        c.csrread  = (rd != 5'd0);
                        c.csrwrite = 1'b1;
                    end
                    default: begin  // csrrs, csrrc and immediates
                        c.regwrite = 1'b1;
                        c.csrread  = 1'b1;
                        c.csrwrite = (rs1 != 5'd0);
                    end
                endcase
            end
            default: c.illegal = 1'b1;
        endcase

        if (stall) begin
            c.regwrite = 1'b0;
            c.memwrite = 1'b0;
            c.csrwrite = 1'b0;
            c.csrread  = 1'b0;
        end
        if (lane.flush) begin  // squashed, nothing redirects or traps
            c.branch  = 1'b0;
            c.jal     = 1'b0;
            c.jalr    = 1'b0;
            c.illegal = 1'b0;
        end
        c.stalled = stall;
    end

    assign ctrl_out.valid = lane.valid;
    assign ctrl_out.ctrl  = c;
    assign ctrl_out.rd    = rd;
    assign ctrl_out.rs1   = rs1;

    a_onehot_mem: assert property (@(posedge lane.clk)
        lane.valid |-> $onehot0(c.loadcntrl) && $onehot0(c.storecntrl));

endmodule

// File: src/decode_dispatch.sv
`include "decode_params.svh"

module decode_dispatch (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  decode_pkg::instr_u [`DEC_LANES-1:0] in_instr,
    input  logic                                in_flush,
    input  logic                                in_hazard,
    lane_in_if.dispatch                         lanes [`DEC_LANES]
);

    decode_pkg::instr_u [`DEC_LANES-1:0] instr_q;
    logic                                valid_q;
    logic                                flush_q;
    logic                                hazard_q;
    logic [`DEC_LANES-1:0]               raw;  // reads rd of an earlier lane
    logic [`DEC_LANES-1:0]               hz;

    // store and branch are the only opcodes without a destination
    function automatic logic writes_rd(decode_pkg::instr_u ins);
        return (ins.r.opcode != decode_pkg::op_store) &&
               (ins.r.opcode != decode_pkg::op_branch);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            flush_q  <= 1'b0;
            hazard_q <= 1'b0;
        end else begin
            valid_q  <= in_valid;
            flush_q  <= in_flush;
            hazard_q <= in_hazard;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= in_instr;
    end

    ////////////////////////////////////////////////////
    // intra-bundle RAW check
    ////////////////////////////////////////////////////
    always_comb begin
        raw = '0;
        for (int k = 1; k < `DEC_LANES; k++) begin
            for (int j = 0; j < k; j++) begin
                if (writes_rd(instr_q[j]) && (instr_q[j].r.rd != 5'd0) &&
                    ((instr_q[k].r.rs1 == instr_q[j].r.rd) ||
                     (instr_q[k].r.rs2 == instr_q[j].r.rd))) begin
                    raw[k] = 1'b1;
                end
            end
        end
    end

    // once a lane stalls, every younger lane stalls with it
    always_comb begin
        logic prev;
        prev = hazard_q;
        for (int k = 0; k < `DEC_LANES; k++) begin
            prev  = prev | raw[k];
            hz[k] = prev;
        end
    end

    for (genvar k = 0; k < `DEC_LANES; k++) begin : g_lane
        assign lanes[k].instr    = instr_q[k];
        assign lanes[k].valid    = valid_q;
        assign lanes[k].ins_zero = (instr_q[k] == '0);
        assign lanes[k].flush    = flush_q;
        assign lanes[k].hazard   = hz[k];

        if (k > 0) begin : g_chk
            a_hz_younger: assert property (@(posedge clk) disable iff (!rst_n)
                lanes[k-1].hazard |-> lanes[k].hazard);
        end
    end

endmodule

// File: src/decode_ifs.sv
// one registered instruction slot, dispatch to decoder
interface lane_in_if (
    input logic clk
);
    decode_pkg::instr_u instr;
    logic               valid;
    logic               ins_zero;  // all-zero bubble
    logic               flush;
    logic               hazard;

    modport dispatch (
        output instr, valid, ins_zero, flush, hazard
    );

    modport decoder (
        input clk, instr, valid, ins_zero, flush, hazard
    );
endinterface

// decoded lane, decoder to collector
interface lane_ctrl_if;
    logic                   valid;
    decode_pkg::ctrl_word_t ctrl;
    logic [4:0]             rd;
    logic [4:0]             rs1;

    modport decoder (
        output valid, ctrl, rd, rs1
    );

    modport collector (
        input valid, ctrl, rd, rs1
    );
endinterface

// File: src/decode_pkg.sv
package decode_pkg;

    // major opcodes of RV32IM handled by the decoder
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_op     = 7'b0110011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_system = 7'b1110011
    } opcode_e;

    // one instruction word, seen as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] funct12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    typedef struct packed {
        logic [2:0] alusel;
        logic [2:0] mulsel;
        logic [2:0] divsel;
        logic [2:0] storecntrl;  // sw, sh, sb
        logic [4:0] loadcntrl;   // lhu, lbu, lw, lh, lb
        logic [3:0] cmpcntrl;    // sltiu, slti, sltu, slt
        logic       branch;
        logic       beq;
        logic       bne;
        logic       blt;
        logic       bge;
        logic       bltu;
        logic       bgeu;
        logic       memread;
        logic       memwrite;
        logic       regwrite;
        logic       alusrc;
        logic       compare;
        logic       auipc;
        logic       lui;
        logic       jal;
        logic       jalr;
        logic [2:0] csrsel;
        logic       csrwrite;
        logic       csrread;
        logic       trap_ret;
        logic       mul_inst;
        logic       div_inst;
        logic       illegal;
        logic       stalled;     // flush, hazard or bubble
    } ctrl_word_t;

endpackage

// File: include/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// instructions decoded per cycle, 1 to 4
`define DEC_LANES 2

`define INSTR_W 32

// lane index width, never below one bit
`define DEC_LANE_W (((`DEC_LANES) > 1) ? $clog2(`DEC_LANES) : 1)

`endif
